// File: verilog/mem_defs.svh
// ################################################
// Memory front end widths and constants
// ################################################

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Data and instruction word width
`define MEM_XLEN 32

// Byte address width
`define MEM_ALEN 32

// One strobe bit per byte lane
`define MEM_STRB 4

// First fetch address after reset
`define MEM_PC_INIT 32'h0000_0000

// Sequential fetch advance, one word
`define MEM_PC_STEP 32'd4

`endif

// File: verilog/mem_pkg.sv
// ################################################
// Memory front end shared types
// ################################################

`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

    // Load and store size, same encoding as RV32I funct3
    typedef enum logic [2:0] {
        SZ_B  = 3'b000,
        SZ_H  = 3'b001,
        SZ_W  = 3'b010,
        SZ_BU = 3'b100,
        SZ_HU = 3'b101
    } size_e;

    // Data port request as issued by the client
    typedef struct packed {
        logic [`MEM_ALEN-1:0] addr;
        logic [`MEM_XLEN-1:0] wdata;
        size_e                size;
        logic                 is_store;
    } lsu_req_t;

    // Data port response, rdata is zero for stores
    typedef struct packed {
        logic [`MEM_XLEN-1:0] rdata;
        logic                 is_store;
    } lsu_rsp_t;

    // One fetched instruction and where it came from
    typedef struct packed {
        logic [`MEM_ALEN-1:0] pc;
        logic [`MEM_XLEN-1:0] instr;
    } fetch_rsp_t;

    // Bus-ready form of a data request
    typedef struct packed {
        logic [`MEM_ALEN-1:0] addr;
        logic [`MEM_XLEN-1:0] wdata;
        logic [`MEM_STRB-1:0] wstrb;
        logic                 write;
    } bus_req_t;

endpackage

`default_nettype wire

// File: verilog/fetch_unit.sv
// ################################################
// Instruction fetch unit
// ################################################

`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 redirect_valid,
    input  logic [`MEM_ALEN-1:0] redirect_pc,
    output logic                 fetch_req,
    output logic [`MEM_ALEN-1:0] fetch_addr,
    input  logic                 fetch_done,
    input  logic [`MEM_XLEN-1:0] fetch_word,
    output mem_pkg::fetch_rsp_t  fetch_rsp,
    output logic                 fetch_valid,
    input  logic                 fetch_ready
);

    logic [`MEM_ALEN-1:0] pc_q;
    // Word on the bus belongs to a path that was redirected away
    logic                 stale_q;
    logic                 slot_take;
    logic                 keep_word;

    assign slot_take = fetch_valid && fetch_ready;

    // Redirect in the same cycle also throws the word away
    assign keep_word = fetch_done && !stale_q && !redirect_valid;

    // Ask for the next word only if the slot has room for it
    assign fetch_req  = !fetch_valid || slot_take;
    // PC only moves on completion or redirect, so the address holds
    assign fetch_addr = pc_q;

    // ################################################
    // PC, slot state and stale tracking
    // ################################################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q        <= `MEM_PC_INIT;
            fetch_valid <= 1'b0;
            stale_q     <= 1'b0;
        end else begin
            if (redirect_valid) begin
                // New path, anything buffered is from the old one
                pc_q        <= redirect_pc;
                fetch_valid <= 1'b0;
            end else if (keep_word) begin
                pc_q        <= pc_q + `MEM_PC_STEP;
                fetch_valid <= 1'b1;
            end else if (slot_take) begin
                fetch_valid <= 1'b0;
            end

            // Any fetch possibly on the bus at a redirect gets dropped
            if (fetch_done) begin
                stale_q <= 1'b0;
            end else if (redirect_valid) begin
                stale_q <= stale_q || fetch_req;
            end
        end
    end

    // Slot payload, written only while the slot is empty
    always_ff @(posedge clk) begin
        if (keep_word) begin
            fetch_rsp.pc    <= pc_q;
            fetch_rsp.instr <= fetch_word;
        end
    end

endmodule

`default_nettype wire

// File: verilog/bus_fsm.sv
// ################################################
// AXI-lite master and request arbiter
// ################################################

`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module bus_fsm (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 fetch_req,
    input  logic [`MEM_ALEN-1:0] fetch_addr,
    output logic                 fetch_done,
    output logic [`MEM_XLEN-1:0] fetch_word,
    input  logic                 data_req_valid,
    output logic                 data_req_ready,
    input  mem_pkg::bus_req_t    bus_req,
    input  logic                 lane_busy,
    output logic                 data_done,
    output logic [`MEM_XLEN-1:0] read_word,
    output logic [`MEM_ALEN-1:0] m_axil_awaddr,
    output logic                 m_axil_awvalid,
    input  logic                 m_axil_awready,
    output logic [`MEM_XLEN-1:0] m_axil_wdata,
    output logic [`MEM_STRB-1:0] m_axil_wstrb,
    output logic                 m_axil_wvalid,
    input  logic                 m_axil_wready,
    input  logic                 m_axil_bvalid,
    output logic                 m_axil_bready,
    output logic [`MEM_ALEN-1:0] m_axil_araddr,
    output logic                 m_axil_arvalid,
    input  logic                 m_axil_arready,
    input  logic [`MEM_XLEN-1:0] m_axil_rdata,
    input  logic                 m_axil_rvalid,
    output logic                 m_axil_rready
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        FETCH
    } state_t;

    state_t               state_q;
    state_t               state_d;
    // Set while idle, low for the first cycle out of reset
    logic                 ready_q;
    logic                 data_go;
    logic                 fetch_go;
    logic                 b_hs;
    logic                 r_hs;
    logic [`MEM_ALEN-1:0] addr_q;
    logic [`MEM_XLEN-1:0] wdata_q;
    logic [`MEM_STRB-1:0] wstrb_q;

    assign data_req_ready = ready_q && !lane_busy;
    assign data_go        = data_req_valid && data_req_ready;
    // Data has priority, a fetch waits if data could go this cycle
    assign fetch_go = (state_q == IDLE) && fetch_req && !(data_req_valid && !lane_busy);

    assign b_hs = m_axil_bvalid && m_axil_bready;
    assign r_hs = m_axil_rvalid && m_axil_rready;

    // Completion pulses, R data goes to whoever asked
    assign data_done  = ((state_q == WRITE) && b_hs) || ((state_q == READ) && r_hs);
    assign fetch_done = (state_q == FETCH) && r_hs;
    assign read_word  = m_axil_rdata;
    assign fetch_word = m_axil_rdata;

    // Single address register serves both channels
    assign m_axil_awaddr = addr_q;
    assign m_axil_araddr = addr_q;
    assign m_axil_wdata  = wdata_q;
    assign m_axil_wstrb  = wstrb_q;

    // ################################################
    // State sequencing
    // ################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (data_go) begin
                    state_d = bus_req.write ? WRITE : READ;
                end else if (fetch_go) begin
                    state_d = FETCH;
                end
            end
            WRITE: begin
                if (b_hs) begin
                    state_d = IDLE;
                end
            end
            READ, FETCH: begin
                if (r_hs) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q        <= IDLE;
            ready_q        <= 1'b0;
            m_axil_awvalid <= 1'b0;
            m_axil_wvalid  <= 1'b0;
            m_axil_bready  <= 1'b0;
            m_axil_arvalid <= 1'b0;
            m_axil_rready  <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == IDLE);

            // AW and W retire independently
            if (m_axil_awready) begin
                m_axil_awvalid <= 1'b0;
            end
            if (m_axil_wready) begin
                m_axil_wvalid <= 1'b0;
            end
            if (b_hs) begin
                m_axil_bready <= 1'b0;
            end
            if (m_axil_arready) begin
                m_axil_arvalid <= 1'b0;
            end
            if (r_hs) begin
                m_axil_rready <= 1'b0;
            end

            // Channels open the cycle after acceptance
            if (data_go && bus_req.write) begin
                m_axil_awvalid <= 1'b1;
                m_axil_wvalid  <= 1'b1;
                m_axil_bready  <= 1'b1;
            end else if (data_go || fetch_go) begin
                m_axil_arvalid <= 1'b1;
                m_axil_rready  <= 1'b1;
            end
        end
    end

    // Transaction payload, held until the state returns to IDLE
    always_ff @(posedge clk) begin
        if (data_go) begin
            addr_q  <= bus_req.addr;
            wdata_q <= bus_req.wdata;
            wstrb_q <= bus_req.wstrb;
        end else if (fetch_go) begin
            addr_q <= fetch_addr;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lsu_lanes.sv
// ################################################
// Load and store lane handling
// ################################################

`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module lsu_lanes (
    input  logic                 clk,
    input  logic                 rstn,
    input  mem_pkg::lsu_req_t    data_req,
    output mem_pkg::bus_req_t    bus_req,
    output logic                 lane_busy,
    input  logic                 data_done,
    input  logic [`MEM_XLEN-1:0] read_word,
    output mem_pkg::lsu_rsp_t    data_rsp,
    output logic                 data_rsp_valid,
    input  logic                 data_rsp_ready
);

    import mem_pkg::*;

    logic [`MEM_STRB-1:0] lane_mask;
    logic [`MEM_XLEN-1:0] lane_data;
    logic [`MEM_XLEN-1:0] shifted;
    logic [`MEM_XLEN-1:0] load_val;

    // ################################################
    // Store side
    // ################################################

    // Replicate the low byte or half into every lane it can land in
    always_comb begin
        case (data_req.size)
            SZ_B, SZ_BU: begin
                lane_mask = 4'b0001;
                lane_data = {4{data_req.wdata[7:0]}};
            end
            SZ_H, SZ_HU: begin
                lane_mask = 4'b0011;
                lane_data = {2{data_req.wdata[15:0]}};
            end
            default: begin
                lane_mask = 4'b1111;
                lane_data = data_req.wdata;
            end
        endcase
    end

    assign bus_req.addr  = data_req.addr;
    assign bus_req.wdata = lane_data;
    // Strobe moves with the byte offset inside the word
    assign bus_req.wstrb = lane_mask << data_req.addr[1:0];
    assign bus_req.write = data_req.is_store;

    // ################################################
    // Load side
    // ################################################

    // Bring the addressed byte or half down to bit 0
    assign shifted = read_word >> {data_req.addr[1:0], 3'b000};

    always_comb begin
        case (data_req.size)
            SZ_B:    load_val = {{24{shifted[7]}}, shifted[7:0]};
            SZ_H:    load_val = {{16{shifted[15]}}, shifted[15:0]};
            SZ_BU:   load_val = {24'd0, shifted[7:0]};
            SZ_HU:   load_val = {16'd0, shifted[15:0]};
            default: load_val = read_word;
        endcase
    end

    // Response slot, the client keeps data_req up until the response
    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_rsp_valid <= 1'b0;
        end else if (data_done) begin
            data_rsp_valid <= 1'b1;
        end else if (data_rsp_valid && data_rsp_ready) begin
            data_rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (data_done) begin
            data_rsp.rdata    <= data_req.is_store ? '0 : load_val;
            data_rsp.is_store <= data_req.is_store;
        end
    end

    // Holding a response stops the next data acceptance
    assign lane_busy = data_rsp_valid;

endmodule

`default_nettype wire

// File: verilog/mem_frontend.sv
// ################################################
// Memory access front end top
// ################################################

`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module mem_frontend (
    input  logic                 clk,
    input  logic                 rstn,

    // Data client
    input  mem_pkg::lsu_req_t    data_req,
    input  logic                 data_req_valid,
    output logic                 data_req_ready,
    output mem_pkg::lsu_rsp_t    data_rsp,
    output logic                 data_rsp_valid,
    input  logic                 data_rsp_ready,

    // Fetch client
    output mem_pkg::fetch_rsp_t  fetch_rsp,
    output logic                 fetch_valid,
    input  logic                 fetch_ready,
    input  logic                 redirect_valid,
    input  logic [`MEM_ALEN-1:0] redirect_pc,

    // AXI-lite master
    output logic [`MEM_ALEN-1:0] m_axil_awaddr,
    output logic                 m_axil_awvalid,
    input  logic                 m_axil_awready,
    output logic [`MEM_XLEN-1:0] m_axil_wdata,
    output logic [`MEM_STRB-1:0] m_axil_wstrb,
    output logic                 m_axil_wvalid,
    input  logic                 m_axil_wready,
    input  logic                 m_axil_bvalid,
    output logic                 m_axil_bready,
    output logic [`MEM_ALEN-1:0] m_axil_araddr,
    output logic                 m_axil_arvalid,
    input  logic                 m_axil_arready,
    input  logic [`MEM_XLEN-1:0] m_axil_rdata,
    input  logic                 m_axil_rvalid,
    output logic                 m_axil_rready
);

    import mem_pkg::*;

    // Fetch unit to arbiter
    logic                 fetch_req;
    logic [`MEM_ALEN-1:0] fetch_addr;
    logic                 fetch_done;
    logic [`MEM_XLEN-1:0] fetch_word;

    // Lane formatter to arbiter and back
    bus_req_t             lane_req;
    logic                 lane_busy;
    logic                 data_done;
    logic [`MEM_XLEN-1:0] read_word;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .fetch_done     (fetch_done),
        .fetch_word     (fetch_word),
        .fetch_rsp      (fetch_rsp),
        .fetch_valid    (fetch_valid),
        .fetch_ready    (fetch_ready)
    );

    bus_fsm u_bus_fsm (
        .clk            (clk),
        .rstn           (rstn),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .fetch_done     (fetch_done),
        .fetch_word     (fetch_word),
        .data_req_valid (data_req_valid),
        .data_req_ready (data_req_ready),
        .bus_req        (lane_req),
        .lane_busy      (lane_busy),
        .data_done      (data_done),
        .read_word      (read_word),
        .m_axil_awaddr  (m_axil_awaddr),
        .m_axil_awvalid (m_axil_awvalid),
        .m_axil_awready (m_axil_awready),
        .m_axil_wdata   (m_axil_wdata),
        .m_axil_wstrb   (m_axil_wstrb),
        .m_axil_wvalid  (m_axil_wvalid),
        .m_axil_wready  (m_axil_wready),
        .m_axil_bvalid  (m_axil_bvalid),
        .m_axil_bready  (m_axil_bready),
        .m_axil_araddr  (m_axil_araddr),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_arready (m_axil_arready),
        .m_axil_rdata   (m_axil_rdata),
        .m_axil_rvalid  (m_axil_rvalid),
        .m_axil_rready  (m_axil_rready)
    );

    lsu_lanes u_lsu_lanes (
        .clk            (clk),
        .rstn           (rstn),
        .data_req       (data_req),
        .bus_req        (lane_req),
        .lane_busy      (lane_busy),
        .data_done      (data_done),
        .read_word      (read_word),
        .data_rsp       (data_rsp),
        .data_rsp_valid (data_rsp_valid),
        .data_rsp_ready (data_rsp_ready)
    );

endmodule

`default_nettype wire

// File: tb/mem_frontend_chk.sv
// ################################################
// Handshake assertions
// ################################################

`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module mem_frontend_chk (
    input logic                 clk,
    input logic                 rstn,
    input mem_pkg::lsu_req_t    data_req,
    input logic                 data_req_valid,
    input logic                 data_req_ready,
    input mem_pkg::lsu_rsp_t    data_rsp,
    input logic                 data_rsp_valid,
    input logic                 data_rsp_ready,
    input mem_pkg::fetch_rsp_t  fetch_rsp,
    input logic                 fetch_valid,
    input logic                 fetch_ready,
    input logic                 redirect_valid,
    input logic [`MEM_ALEN-1:0] m_axil_awaddr,
    input logic                 m_axil_awvalid,
    input logic                 m_axil_awready,
    input logic                 m_axil_wvalid,
    input logic                 m_axil_wready,
    input logic                 m_axil_bready,
    input logic [`MEM_ALEN-1:0] m_axil_araddr,
    input logic                 m_axil_arvalid,
    input logic                 m_axil_arready,
    input logic                 m_axil_rready
);

    // AXI-lite valids wait for their ready
    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        m_axil_awvalid && !m_axil_awready |=> m_axil_awvalid && $stable(m_axil_awaddr))
        else $error("AW valid dropped before ready");
    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        m_axil_wvalid && !m_axil_wready |=> m_axil_wvalid)
        else $error("W valid dropped before ready");
    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        m_axil_arvalid && !m_axil_arready |=> m_axil_arvalid && $stable(m_axil_araddr))
        else $error("AR valid dropped before ready");

    // One transaction at a time
    one_pending: assert property (@(posedge clk) disable iff (!rstn)
        !(m_axil_arvalid && m_axil_awvalid))
        else $error("AR and AW pending together");

    // Client payloads hold under back-pressure
    req_hold: assert property (@(posedge clk) disable iff (!rstn)
        data_req_valid && !data_req_ready |=> data_req_valid && $stable(data_req))
        else $error("Data request changed before acceptance");
    rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
        data_rsp_valid && !data_rsp_ready |=> data_rsp_valid && $stable(data_rsp))
        else $error("Data response changed before it was taken");
    // A redirect is allowed to empty the slot
    fetch_hold: assert property (@(posedge clk) disable iff (!rstn)
        fetch_valid && !fetch_ready && !redirect_valid |=> fetch_valid && $stable(fetch_rsp))
        else $error("Fetch slot changed before it was taken");

    reset_quiet: assert property (@(posedge clk)
        !rstn |=> !(m_axil_awvalid || m_axil_wvalid || m_axil_arvalid || m_axil_bready
                    || m_axil_rready || data_rsp_valid || fetch_valid || data_req_ready))
        else $error("Valid or ready output high after reset");

endmodule

bind mem_frontend mem_frontend_chk i_mem_frontend_chk (.*);

`default_nettype wire

// File: tb/mem_frontend_tb.sv
// ################################################
// Memory front end testbench
// ################################################

`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module mem_frontend_tb;

    import mem_pkg::*;

    localparam int          MEM_WORDS     = 4096;
    localparam int          MAX_OPS       = 64;
    localparam logic [31:0] INSTR_PATTERN = 32'hA5C3_0F00;
    // Slave delays are 2 random bits, so at most 3 wait cycles plus the beat
    localparam int          DELAY_WORST   = 4;
    localparam int          MARGIN        = 8;

    logic                 clk;
    logic                 rstn;
    lsu_req_t             data_req;
    logic                 data_req_valid;
    logic                 data_req_ready;
    lsu_rsp_t             data_rsp;
    logic                 data_rsp_valid;
    logic                 data_rsp_ready = 1'b0;
    fetch_rsp_t           fetch_rsp;
    logic                 fetch_valid;
    logic                 fetch_ready;
    logic                 fetch_ready_rnd = 1'b0;
    logic                 redirect_valid;
    logic [`MEM_ALEN-1:0] redirect_pc;
    logic [`MEM_ALEN-1:0] m_axil_awaddr;
    logic                 m_axil_awvalid;
    logic                 m_axil_awready = 1'b0;
    logic [`MEM_XLEN-1:0] m_axil_wdata;
    logic [`MEM_STRB-1:0] m_axil_wstrb;
    logic                 m_axil_wvalid;
    logic                 m_axil_wready = 1'b0;
    logic                 m_axil_bvalid = 1'b0;
    logic                 m_axil_bready;
    logic [`MEM_ALEN-1:0] m_axil_araddr;
    logic                 m_axil_arvalid;
    logic                 m_axil_arready = 1'b0;
    logic [`MEM_XLEN-1:0] m_axil_rdata = '0;
    logic                 m_axil_rvalid = 1'b0;
    logic                 m_axil_rready;

    // Slave memory and the operation list
    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] op_mem [0:MAX_OPS*4-1];

    logic [31:0]          lfsr_state;
    int                   cycles = 0;
    int                   timeout_limit = 100000;
    int                   fetch_count = 0;
    int                   issued = 0;
    int                   rsp_count = 0;
    logic [`MEM_ALEN-1:0] exp_pc = `MEM_PC_INIT;
    logic [31:0]          exp_wdata = '0;
    logic [3:0]           exp_wstrb = '0;

    // Slave channel state
    int          aw_wait = 0;
    int          w_wait = 0;
    int          ar_wait = 0;
    int          r_wait = 0;
    logic        aw_got = 1'b0;
    logic        w_got = 1'b0;
    logic        ar_got = 1'b0;
    logic [31:0] aw_addr_l = '0;
    logic [31:0] w_data_l = '0;
    logic [3:0]  w_strb_l = '0;
    logic [31:0] ar_addr_l = '0;

    // A redirect cycle never takes the slot
    assign fetch_ready = fetch_ready_rnd && !redirect_valid;

    mem_frontend i_mem_frontend (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ################################################
    // Helpers
    // ################################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // Lane rule for stores: replicate and shift the size mask by the offset
    task automatic store_lanes(input logic [2:0] size, input logic [31:0] addr,
                               input logic [31:0] data, output logic [31:0] wd,
                               output logic [3:0] strb);
        case (size)
            3'b000: begin
                wd   = {4{data[7:0]}};
                strb = 4'b0001 << addr[1:0];
            end
            3'b001: begin
                wd   = {2{data[15:0]}};
                strb = 4'b0011 << addr[1:0];
            end
            default: begin
                wd   = data;
                strb = 4'b1111;
            end
        endcase
    endtask

    // ################################################
    // Monitors, AXI-lite slave and back-pressure
    // ################################################

    always @(posedge clk) begin
        logic [31:0] rnd;
        logic        b_fire;
        logic        r_fire;
        cycles++;
        if (cycles > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
        b_fire = m_axil_bvalid && m_axil_bready;
        r_fire = m_axil_rvalid && m_axil_rready;
        if (rstn) begin
            // Fetch order, a redirect restarts the expected pc
            if (redirect_valid) begin
                exp_pc = redirect_pc;
            end else if (fetch_valid && fetch_ready) begin
                check(fetch_rsp.pc, exp_pc, "fetch pc");
                check(fetch_rsp.instr, mem[fetch_rsp.pc[13:2]], "fetch word");
                exp_pc = exp_pc + `MEM_PC_STEP;
                fetch_count++;
            end
            if (data_rsp_valid && data_rsp_ready) begin
                rsp_count++;
                check(rsp_count, issued, "response count");
            end
            if (m_axil_awvalid && m_axil_awready) begin
                check(m_axil_awaddr, data_req.addr, "store address");
                aw_got    = 1'b1;
                aw_addr_l = m_axil_awaddr;
                take_bits(2, rnd);
                aw_wait = rnd;
            end
            if (m_axil_wvalid && m_axil_wready) begin
                w_got    = 1'b1;
                w_data_l = m_axil_wdata;
                w_strb_l = m_axil_wstrb;
                check(m_axil_wdata, exp_wdata, "store wdata");
                check(32'(m_axil_wstrb), 32'(exp_wstrb), "store wstrb");
                take_bits(2, rnd);
                w_wait = rnd;
            end
            if (m_axil_arvalid && m_axil_arready) begin
                ar_got    = 1'b1;
                ar_addr_l = m_axil_araddr;
                take_bits(2, rnd);
                r_wait = rnd;
            end

            #1;
            // Ready pulses last one cycle, valid holds until taken
            if (m_axil_awready) begin
                m_axil_awready = 1'b0;
            end else if (m_axil_awvalid && !aw_got) begin
                if (aw_wait == 0) m_axil_awready = 1'b1;
                else aw_wait--;
            end
            if (m_axil_wready) begin
                m_axil_wready = 1'b0;
            end else if (m_axil_wvalid && !w_got) begin
                if (w_wait == 0) m_axil_wready = 1'b1;
                else w_wait--;
            end
            // Write lands in memory once both address and data are in
            if (b_fire) begin
                m_axil_bvalid = 1'b0;
            end else if (aw_got && w_got && !m_axil_bvalid) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_strb_l[b]) mem[aw_addr_l[13:2]][b*8 +: 8] = w_data_l[b*8 +: 8];
                end
                m_axil_bvalid = 1'b1;
                aw_got        = 1'b0;
                w_got         = 1'b0;
            end
            if (m_axil_arready) begin
                m_axil_arready = 1'b0;
            end else if (m_axil_arvalid && !ar_got) begin
                if (ar_wait == 0) m_axil_arready = 1'b1;
                else ar_wait--;
            end
            if (r_fire) begin
                m_axil_rvalid = 1'b0;
                ar_got        = 1'b0;
                take_bits(2, rnd);
                ar_wait = rnd;
            end else if (ar_got && !m_axil_rvalid) begin
                if (r_wait == 0) begin
                    m_axil_rdata  = mem[ar_addr_l[13:2]];
                    m_axil_rvalid = 1'b1;
                end else begin
                    r_wait--;
                end
            end
            // Client ready about three quarters of the time
            take_bits(2, rnd);
            fetch_ready_rnd = (rnd[1:0] != 2'b00);
            take_bits(2, rnd);
            data_rsp_ready = (rnd[1:0] != 2'b00);
        end
    end

    // ################################################
    // Stimulus from the operation file
    // ################################################

    initial begin
        int          n_ops;
        int          target;
        logic [31:0] kind;
        logic [31:0] size;
        logic [31:0] addr;
        logic [31:0] value;
        lfsr_state     = 32'h800c;
        rstn           = 1'b0;
        data_req       = '0;
        data_req_valid = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        // Instruction words below 0x2000, data region zero
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i < 2048) ? (32'(i) ^ INSTR_PATTERN) : 32'h0;
        end
        for (int i = 0; i < MAX_OPS*4; i++) begin
            op_mem[i] = '0;
        end
        $readmemh("tb/mem_input.txt", op_mem);
        n_ops = 0;
        while (n_ops < MAX_OPS && op_mem[n_ops*4] != 0) begin
            n_ops++;
        end
        // Each op uses up to six channel waits, plus a fetch ahead of it
        timeout_limit = (n_ops + 4) * 6 * DELAY_WORST * MARGIN;

        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        for (int k = 0; k < n_ops; k++) begin
            kind  = op_mem[k*4];
            size  = op_mem[k*4+1];
            addr  = op_mem[k*4+2];
            value = op_mem[k*4+3];
            if (kind == 3) begin
                redirect_pc    = addr;
                redirect_valid = 1'b1;
                @(posedge clk);
                #1;
                redirect_valid = 1'b0;
                // Let a few words of the new path come through
                target = fetch_count + 3;
                while (fetch_count < target) begin
                    @(posedge clk);
                    #1;
                end
            end else begin
                data_req.addr     = addr;
                data_req.wdata    = (kind == 1) ? value : 32'h0;
                data_req.size     = size_e'(size[2:0]);
                data_req.is_store = (kind == 1);
                store_lanes(size[2:0], addr, value, exp_wdata, exp_wstrb);
                data_req_valid = 1'b1;
                do @(posedge clk); while (!data_req_ready);
                #1;
                data_req_valid = 1'b0;
                issued++;
                // Request stays on the port until its response is taken
                do @(posedge clk); while (!(data_rsp_valid && data_rsp_ready));
                check(32'(data_rsp.is_store), 32'(kind == 1), "response kind");
                check(data_rsp.rdata, (kind == 1) ? 32'h0 : value, "load result");
                #1;
            end
        end

        target = fetch_count + 4;
        while (fetch_count < target) begin
            @(posedge clk);
            #1;
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mem_input.txt
// Columns: kind size addr value, all hex
// kind 1 store (value = data), 2 load (value = expected), 3 redirect (addr = target), 0 end
1 2 00002000 80f17e82
2 2 00002000 80f17e82
2 0 00002000 ffffff82
2 0 00002001 0000007e
3 0 00000100 00000000
2 0 00002002 fffffff1
2 0 00002003 ffffff80
2 4 00002000 00000082
2 4 00002001 0000007e
2 4 00002002 000000f1
2 4 00002003 00000080
2 1 00002000 00007e82
2 1 00002002 ffff80f1
2 5 00002000 00007e82
2 5 00002002 000080f1
1 0 00002005 123456c3
1 1 00002006 abcd9a5e
3 0 00000040 00000000
1 0 00002004 00000011
2 2 00002004 9a5ec311
2 1 00002006 ffff9a5e
2 0 00002005 ffffffc3
2 5 00002004 0000c311
2 1 00002004 ffffc311
0 0 00000000 00000000

// File: src.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/fetch_unit.sv
verilog/bus_fsm.sv
verilog/lsu_lanes.sv
verilog/mem_frontend.sv
tb/mem_frontend_chk.sv
tb/mem_frontend_tb.sv

// File: Makefile
# Verilator build and run for the memory front end

VERILATOR ?= verilator
TOP       ?= mem_frontend_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
